// ==== hdl/backup_ctrl.sv ====
// Backup RAM control tracking the mounted save image and raising load and save requests
`timescale 1ns/1ps

module backup_ctrl (
	input  logic                            clk_1x,
	input  logic                            rst_n,
	input  logic                            cart_download,
	input  logic                            osd_status,
	input  logic                            img_mounted,
	input  logic                            img_readonly,
	input  logic [n64_host_pkg::word_w-1:0] img_size,
	input  logic                            autosave_off,
	input  logic                            bk_reload_req,
	input  logic                            bk_save_req,
	output logic                            bk_load,
	output logic                            bk_save,
	output logic                            bk_mounted
);

	logic osd_status_d;
	logic cart_download_d;
	logic use_img;
	logic osd_open;
	logic img_writable;

	// Menu opening edge triggers an autosave
	assign osd_open     = osd_status & ~osd_status_d;
	assign img_writable = img_mounted && (img_size != '0) && !img_readonly;

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			osd_status_d    <= 1'b0;
			cart_download_d <= 1'b0;
			use_img         <= 1'b0;
		end else begin
			osd_status_d    <= osd_status;
			cart_download_d <= cart_download;
			// New cart forgets the previous save image
			if (cart_download && !cart_download_d) begin
				use_img <= 1'b0;
			end
			if (img_writable) begin
				use_img <= 1'b1;
			end
		end
	end

	assign bk_load    = bk_reload_req | (cart_download & img_mounted);
	assign bk_save    = bk_save_req | (osd_open & ~autosave_off);
	assign bk_mounted = use_img;

endmodule

// ==== hdl/cart_writer.sv ====
// Cart loader that packs beat pairs into RAM writes and stalls the loader until accepted
`timescale 1ns/1ps

module cart_writer #(
	parameter int cart_start = 8388608
) (
	input  logic                                  clk_1x,
	input  logic                                  rst_n,
	input  logic                                  ioctl_download,
	input  logic [7:0]                            ioctl_index,
	input  logic [n64_host_pkg::ioctl_addr_w-1:0] ioctl_addr,
	input  logic [n64_host_pkg::ioctl_data_w-1:0] ioctl_dout,
	input  logic                                  ioctl_wr,
	input  logic                                  ram_ready,
	output logic [n64_host_pkg::ioctl_addr_w-1:0] ram_addr,
	output logic [n64_host_pkg::word_w-1:0]       ram_wrdata,
	output logic                                  ram_wr,
	output logic                                  ioctl_wait,
	output logic                                  cart_download,
	output logic                                  cart_loaded
);

	import n64_host_pkg::*;

	localparam logic [ioctl_addr_w-1:0] cart_base = ioctl_addr_w'(cart_start);

	logic beat_wr;

	assign beat_wr = cart_download & ioctl_wr;

	// ========================================================================
	// Request and wait control
	// ========================================================================
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			cart_download <= 1'b0;
			cart_loaded   <= 1'b0;
			ram_wr        <= 1'b0;
			ioctl_wait    <= 1'b0;
		end else begin
			cart_download <= ioctl_download && (ioctl_index[5:0] == dl_cart);
			ram_wr        <= 1'b0;
			if (cart_download) begin
				cart_loaded <= 1'b1;
				if (beat_wr && ioctl_addr[1]) begin
					ram_wr     <= 1'b1;
					ioctl_wait <= 1'b1;
				end
				// Acceptance releases the loader on the next cycle
				if (ram_ready) begin
					ioctl_wait <= 1'b0;
				end
			end else begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	// ========================================================================
	// Word assembly, low half first
	// ========================================================================
	always_ff @(posedge clk_1x) begin
		if (beat_wr) begin
			if (!ioctl_addr[1]) begin
				ram_wrdata[15:0] <= ioctl_dout;
				ram_addr         <= ioctl_addr + cart_base;
			end else begin
				ram_wrdata[31:16] <= ioctl_dout;
			end
		end
	end

endmodule

// ==== hdl/n64_host_pkg.sv ====
// Host bridge shared widths, download targets, save and EEPROM types, SNAC pin map
package n64_host_pkg;

	// ========================================================================
	// Widths
	// ========================================================================
	localparam int status_w     = 128;
	localparam int ioctl_addr_w = 27;
	localparam int ioctl_data_w = 16;
	localparam int word_w       = 32;
	localparam int pif_addr_w   = 10;
	localparam int user_w       = 7;

	// ========================================================================
	// Encodings
	// ========================================================================

	// Compared against the low six bits of the loader index
	typedef enum logic [5:0] {
		dl_pifrom = 6'd0,
		dl_cart   = 6'd1
	} dl_index_e;

	// Save type field of the system menu
	typedef enum logic [2:0] {
		save_none     = 3'd0,
		save_eeprom4  = 3'd1,
		save_eeprom16 = 3'd2,
		save_sram32   = 3'd3,
		save_sram96   = 3'd4,
		save_flash    = 3'd5
	} save_type_e;

	typedef enum logic [1:0] {
		eeprom_none = 2'd0,
		eeprom_4k   = 2'd1,
		eeprom_16k  = 2'd2
	} eeprom_type_e;

	// Pad index to user port pin: pad 0 on D-, pad 1 on D+, pads 2 and 3 on RX
	localparam logic [3:0][2:0] snac_pin = {3'd4, 3'd5, 3'd0, 3'd1};

endpackage

// ==== hdl/n64_host_top.sv ====
// Host bridge top level joining option decode, ROM loaders, backup control and SNAC routing
`timescale 1ns/1ps

module n64_host_top #(
	parameter int cart_start = 8388608
) (
	input  logic                                    clk_1x,
	input  logic                                    rst_n,

	// Loader link
	input  logic                                    ioctl_download,
	input  logic [7:0]                              ioctl_index,
	input  logic [n64_host_pkg::ioctl_addr_w-1:0]   ioctl_addr,
	input  logic [n64_host_pkg::ioctl_data_w-1:0]   ioctl_dout,
	input  logic                                    ioctl_wr,
	output logic                                    ioctl_wait,

	// PIF ROM write port
	output logic [n64_host_pkg::pif_addr_w-1:0]     pifrom_wraddress,
	output logic [n64_host_pkg::word_w-1:0]         pifrom_wrdata,
	output logic                                    pifrom_wren,

	// Cart RAM write port
	output logic [n64_host_pkg::ioctl_addr_w-1:0]   ram_addr,
	output logic [n64_host_pkg::word_w-1:0]         ram_wrdata,
	output logic                                    ram_wr,
	input  logic                                    ram_ready,
	output logic                                    cart_download,
	output logic                                    cart_loaded,

	// Menu and save image
	input  logic [n64_host_pkg::status_w-1:0]       status,
	input  logic                                    osd_status,
	input  logic                                    img_mounted,
	input  logic                                    img_readonly,
	input  logic [n64_host_pkg::word_w-1:0]         img_size,
	output logic                                    bk_load,
	output logic                                    bk_save,
	output logic                                    bk_mounted,

	// SNAC user port
	input  logic [1:0]                              snac_padindex,
	input  logic                                    snac_out,
	output logic                                    snac_in,
	input  logic [n64_host_pkg::user_w-1:0]         user_in,
	output logic [n64_host_pkg::user_w-1:0]         user_out,

	// Decoded options
	output logic [12:0]                             video_arx,
	output logic [12:0]                             video_ary,
	output n64_host_pkg::eeprom_type_e              eeprom_type
);

	logic autosave_off;
	logic bk_reload_req;
	logic bk_save_req;
	logic snac_en;

	// ========================================================================
	// Configuration
	// ========================================================================
	option_regs u_option_regs (
		.clk_1x        (clk_1x),
		.rst_n         (rst_n),
		.status        (status),
		.autosave_off  (autosave_off),
		.bk_reload_req (bk_reload_req),
		.bk_save_req   (bk_save_req),
		.snac_en       (snac_en),
		.video_arx     (video_arx),
		.video_ary     (video_ary),
		.eeprom_type   (eeprom_type)
	);

	// ========================================================================
	// Loaders
	// ========================================================================
	pifrom_packer u_pifrom_packer (
		.clk_1x           (clk_1x),
		.rst_n            (rst_n),
		.ioctl_download   (ioctl_download),
		.ioctl_index      (ioctl_index),
		.ioctl_addr       (ioctl_addr),
		.ioctl_dout       (ioctl_dout),
		.ioctl_wr         (ioctl_wr),
		.pifrom_wraddress (pifrom_wraddress),
		.pifrom_wrdata    (pifrom_wrdata),
		.pifrom_wren      (pifrom_wren)
	);

	cart_writer #(
		.cart_start (cart_start)
	) u_cart_writer (
		.clk_1x         (clk_1x),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.ram_ready      (ram_ready),
		.ram_addr       (ram_addr),
		.ram_wrdata     (ram_wrdata),
		.ram_wr         (ram_wr),
		.ioctl_wait     (ioctl_wait),
		.cart_download  (cart_download),
		.cart_loaded    (cart_loaded)
	);

	// ========================================================================
	// Backup RAM and SNAC
	// ========================================================================
	backup_ctrl u_backup_ctrl (
		.clk_1x        (clk_1x),
		.rst_n         (rst_n),
		.cart_download (cart_download),
		.osd_status    (osd_status),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size      (img_size),
		.autosave_off  (autosave_off),
		.bk_reload_req (bk_reload_req),
		.bk_save_req   (bk_save_req),
		.bk_load       (bk_load),
		.bk_save       (bk_save),
		.bk_mounted    (bk_mounted)
	);

	snac_port_mux u_snac_port_mux (
		.clk_1x        (clk_1x),
		.rst_n         (rst_n),
		.snac_en       (snac_en),
		.snac_padindex (snac_padindex),
		.snac_out      (snac_out),
		.user_in       (user_in),
		.user_out      (user_out),
		.snac_in       (snac_in)
	);

endmodule

// ==== hdl/option_regs.sv ====
// Menu status register that decodes aspect ratio, EEPROM type and control bits
`timescale 1ns/1ps

module option_regs (
	input  logic                              clk_1x,
	input  logic                              rst_n,
	input  logic [n64_host_pkg::status_w-1:0] status,
	output logic                              autosave_off,
	output logic                              bk_reload_req,
	output logic                              bk_save_req,
	output logic                              snac_en,
	output logic [12:0]                       video_arx,
	output logic [12:0]                       video_ary,
	output n64_host_pkg::eeprom_type_e        eeprom_type
);

	import n64_host_pkg::*;

	logic [1:0] aspect;
	save_type_e save_type;

	assign aspect    = status[48:47];
	assign save_type = save_type_e'(status[77:75]);

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			autosave_off  <= 1'b0;
			bk_reload_req <= 1'b0;
			bk_save_req   <= 1'b0;
			snac_en       <= 1'b0;
			video_arx     <= '0;
			video_ary     <= '0;
			eeprom_type   <= eeprom_none;
		end else begin
			bk_reload_req <= status[40];
			bk_save_req   <= status[41];
			autosave_off  <= status[42];
			snac_en       <= status[90];

			// Original keeps 4:3, other settings select a scaler preset
			if (aspect == 2'd0) begin
				video_arx <= 13'd4;
				video_ary <= 13'd3;
			end else begin
				video_arx <= {11'd0, aspect - 2'd1};
				video_ary <= 13'd0;
			end

			case (save_type)
				save_eeprom4:  eeprom_type <= eeprom_4k;
				save_eeprom16: eeprom_type <= eeprom_16k;
				save_none, save_sram32, save_sram96, save_flash: eeprom_type <= eeprom_none;
				default:       eeprom_type <= eeprom_none;
			endcase
		end
	end

endmodule

// ==== hdl/pifrom_packer.sv ====
// PIF ROM loader that packs download beat pairs into byte-swapped 32-bit words
`timescale 1ns/1ps

module pifrom_packer (
	input  logic                                  clk_1x,
	input  logic                                  rst_n,
	input  logic                                  ioctl_download,
	input  logic [7:0]                            ioctl_index,
	input  logic [n64_host_pkg::ioctl_addr_w-1:0] ioctl_addr,
	input  logic [n64_host_pkg::ioctl_data_w-1:0] ioctl_dout,
	input  logic                                  ioctl_wr,
	output logic [n64_host_pkg::pif_addr_w-1:0]   pifrom_wraddress,
	output logic [n64_host_pkg::word_w-1:0]       pifrom_wrdata,
	output logic                                  pifrom_wren
);

	import n64_host_pkg::*;

	logic pifrom_download;
	logic beat_wr;

	assign beat_wr = pifrom_download & ioctl_wr;

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			pifrom_download <= 1'b0;
			pifrom_wren     <= 1'b0;
		end else begin
			pifrom_download <= ioctl_download && (ioctl_index[5:0] == dl_pifrom);
			// Second half of the word completes the write
			pifrom_wren     <= beat_wr & ioctl_addr[1];
		end
	end

	// Word data and address, bytes swapped within each beat
	always_ff @(posedge clk_1x) begin
		if (beat_wr) begin
			if (!ioctl_addr[1]) begin
				pifrom_wrdata[31:16] <= {ioctl_dout[7:0], ioctl_dout[15:8]};
				pifrom_wraddress     <= {ioctl_index[6], ioctl_addr[10:2]};
			end else begin
				pifrom_wrdata[15:0]  <= {ioctl_dout[7:0], ioctl_dout[15:8]};
			end
		end
	end

endmodule

// ==== hdl/snac_port_mux.sv ====
// SNAC router that drives one pad line on the open-drain user port and samples its return
`timescale 1ns/1ps

module snac_port_mux (
	input  logic                            clk_1x,
	input  logic                            rst_n,
	input  logic                            snac_en,
	input  logic [1:0]                      snac_padindex,
	input  logic                            snac_out,
	input  logic [n64_host_pkg::user_w-1:0] user_in,
	output logic [n64_host_pkg::user_w-1:0] user_out,
	output logic                            snac_in
);

	import n64_host_pkg::*;

	logic [2:0] sel_pin;

	assign sel_pin = snac_pin[snac_padindex];

	// ========================================================================
	// Port drive
	// ========================================================================

	// A pin driven high is released, so the pad can pull it low
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			user_out <= '1;
			snac_in  <= 1'b1;
		end else if (snac_en) begin
			user_out[2]       <= 1'b1;
			user_out[3]       <= 1'b1;
			user_out[6]       <= 1'b1;
			user_out[sel_pin] <= snac_out;
			snac_in           <= user_in[sel_pin];
		end else begin
			// Parked, everything released
			user_out <= '1;
		end
	end

endmodule

// ==== n64_host_bridge.f ====
hdl/n64_host_pkg.sv
hdl/option_regs.sv
hdl/pifrom_packer.sv
hdl/cart_writer.sv
hdl/backup_ctrl.sv
hdl/snac_port_mux.sv
hdl/n64_host_top.sv
verif/n64_host_tb.sv

// ==== verif/n64_host_tb.sv ====
// Directed testbench for the host bridge covering loaders, backup requests, SNAC and options
`timescale 1ns/1ps

module n64_host_tb;

	import n64_host_pkg::*;

	localparam int cart_start = 8388608;
	// About 600 cycles of tests with worst case RAM latency, doubled and rounded up
	localparam int max_cycles = 2000;

	logic                    clk_1x;
	logic                    rst_n;
	logic                    ioctl_download;
	logic [7:0]              ioctl_index;
	logic [ioctl_addr_w-1:0] ioctl_addr;
	logic [ioctl_data_w-1:0] ioctl_dout;
	logic                    ioctl_wr;
	logic                    ioctl_wait;
	logic [pif_addr_w-1:0]   pifrom_wraddress;
	logic [word_w-1:0]       pifrom_wrdata;
	logic                    pifrom_wren;
	logic [ioctl_addr_w-1:0] ram_addr;
	logic [word_w-1:0]       ram_wrdata;
	logic                    ram_wr;
	logic                    ram_ready;
	logic                    cart_download;
	logic                    cart_loaded;
	logic [status_w-1:0]     status;
	logic                    osd_status;
	logic                    img_mounted;
	logic                    img_readonly;
	logic [word_w-1:0]       img_size;
	logic                    bk_load;
	logic                    bk_save;
	logic                    bk_mounted;
	logic [1:0]              snac_padindex;
	logic                    snac_out;
	logic                    snac_in;
	logic [user_w-1:0]       user_in;
	logic [user_w-1:0]       user_out;
	logic [12:0]             video_arx;
	logic [12:0]             video_ary;
	eeprom_type_e            eeprom_type;

	integer seed = 52;
	int     errors = 0;
	int     tests = 0;
	int     ram_delay = 0;

	n64_host_top #(
		.cart_start (cart_start)
	) UUT (.*);

	initial begin
		clk_1x = 1'b0;
		forever #4 clk_1x = ~clk_1x;
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < max_cycles) begin
			@(posedge clk_1x);
			cycles++;
		end
		$display("Timeout: run stopped after %0d cycles with tests still pending", cycles);
		$display("TESTS FAILED");
		$finish;
	end

	// ========================================================================
	// RAM model, accepts each write 1 to 8 cycles after the request
	// ========================================================================
	initial begin
		ram_ready = 1'b0;
		forever begin
			@(negedge clk_1x);
			if (ram_wr === 1'b1) begin
				ram_delay = ($random(seed) & 7) + 1;
				repeat (ram_delay) @(negedge clk_1x);
				ram_ready = 1'b1;
				@(negedge clk_1x);
				ram_ready = 1'b0;
			end
		end
	end

	// ========================================================================
	// Helpers
	// ========================================================================
	task automatic flag_error(input string msg);
		$display("FAIL %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic report_test(input string name, input int err_before);
		tests++;
		if (errors == err_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - err_before);
	endtask

	// One loader beat, entered and left on a falling edge
	task automatic send_beat(input logic [ioctl_addr_w-1:0] addr, input logic [15:0] data);
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		@(negedge clk_1x);
		ioctl_wr   = 1'b0;
	endtask

	task automatic start_download(input logic [7:0] index);
		ioctl_index    = index;
		ioctl_download = 1'b1;
		@(negedge clk_1x);
	endtask

	task automatic end_download;
		ioctl_download = 1'b0;
		@(negedge clk_1x);
	endtask

	function automatic logic [15:0] swap_bytes(input logic [15:0] d);
		return {d[7:0], d[15:8]};
	endfunction

	// Pad to pin map of the SNAC adapter
	function automatic logic [2:0] pad_pin(input logic [1:0] pad);
		logic [2:0] pin;
		case (pad)
			2'd0:    pin = 3'd1;
			2'd1:    pin = 3'd0;
			2'd2:    pin = 3'd5;
			default: pin = 3'd4;
		endcase
		return pin;
	endfunction

	// ========================================================================
	// Tests
	// ========================================================================
	task automatic check_reset_state;
		int err_before;
		err_before = errors;
		if (pifrom_wren !== 1'b0) flag_error("pifrom_wren set after reset");
		if (ram_wr !== 1'b0) flag_error("ram_wr set after reset");
		if (ioctl_wait !== 1'b0) flag_error("ioctl_wait set after reset");
		if (cart_download !== 1'b0) flag_error("cart_download set after reset");
		if (cart_loaded !== 1'b0) flag_error("cart_loaded set after reset");
		if (bk_mounted !== 1'b0) flag_error("bk_mounted set after reset");
		if (user_out !== {user_w{1'b1}}) flag_error($sformatf("user_out %b after reset", user_out));
		report_test("reset_state", err_before);
	endtask

	task automatic pifrom_packing;
		int err_before;
		logic [7:0] index;
		logic [15:0] hi_beat;
		logic [15:0] lo_beat;
		logic [ioctl_addr_w-1:0] addr;
		logic [pif_addr_w-1:0] exp_addr;
		err_before = errors;
		for (int pass = 0; pass < 2; pass++) begin
			// Index bit 6 selects the upper ROM half
			index = (pass == 0) ? 8'h00 : 8'h40;
			start_download(index);
			for (int k = 0; k < 4; k++) begin
				addr     = 27'(32'h3f0 + k * 4);
				exp_addr = {index[6], addr[10:2]};
				hi_beat  = 16'($random(seed));
				lo_beat  = 16'($random(seed));
				send_beat(addr, hi_beat);
				if (pifrom_wren !== 1'b0) flag_error("pifrom_wren pulsed after first beat");
				send_beat(addr + 27'd2, lo_beat);
				if (pifrom_wren !== 1'b1) flag_error("pifrom_wren missing after second beat");
				if (pifrom_wrdata !== {swap_bytes(hi_beat), swap_bytes(lo_beat)})
					flag_error($sformatf("pifrom_wrdata %h for beats %h %h",
						pifrom_wrdata, hi_beat, lo_beat));
				if (pifrom_wraddress !== exp_addr)
					flag_error($sformatf("pifrom_wraddress %h, expected %h",
						pifrom_wraddress, exp_addr));
				@(negedge clk_1x);
				if (pifrom_wren !== 1'b0) flag_error("pifrom_wren longer than one cycle");
			end
			end_download();
		end
		report_test("pifrom_packing", err_before);
	endtask

	task automatic cart_write_backpressure;
		int err_before;
		int waited;
		logic [15:0] lo_beat;
		logic [15:0] hi_beat;
		logic [ioctl_addr_w-1:0] addr;
		logic [ioctl_addr_w-1:0] exp_addr;
		err_before = errors;
		start_download(8'h01);
		if (cart_download !== 1'b1) flag_error("cart_download not set for cart index");
		for (int k = 0; k < 8; k++) begin
			addr     = 27'(32'h1000 + k * 4);
			exp_addr = addr + 27'(cart_start);
			lo_beat  = 16'($random(seed));
			hi_beat  = 16'($random(seed));
			send_beat(addr, lo_beat);
			if (ram_wr !== 1'b0) flag_error("ram_wr raised after first beat");
			send_beat(addr + 27'd2, hi_beat);
			if (ram_wr !== 1'b1 || ioctl_wait !== 1'b1)
				flag_error("ram_wr and ioctl_wait not raised after second beat");
			if (ram_addr !== exp_addr)
				flag_error($sformatf("ram_addr %h, expected %h", ram_addr, exp_addr));
			if (ram_wrdata !== {hi_beat, lo_beat})
				flag_error($sformatf("ram_wrdata %h, expected %h", ram_wrdata, {hi_beat, lo_beat}));
			// Loader held until the cycle after acceptance
			waited = 0;
			while (ioctl_wait === 1'b1 && waited <= 12) begin
				@(negedge clk_1x);
				waited++;
				if (ram_wr !== 1'b0) flag_error("ram_wr held longer than one cycle");
			end
			if (ioctl_wait === 1'b1) begin
				$display("Error at %0t: write %0d never released the loader", $time, k);
				errors++;
			end else if (waited != ram_delay + 1) begin
				flag_error($sformatf("ioctl_wait fell after %0d cycles, expected %0d",
					waited, ram_delay + 1));
			end
			if (cart_loaded !== 1'b1) flag_error("cart_loaded not set during download");
		end
		// Last word still pending when the download ends
		send_beat(addr + 27'd4, lo_beat);
		send_beat(addr + 27'd6, hi_beat);
		if (ioctl_wait !== 1'b1) flag_error("ioctl_wait not raised for the pending word");
		end_download();
		@(negedge clk_1x);
		if (cart_download !== 1'b0) flag_error("cart_download set after download ended");
		if (cart_loaded !== 1'b1) flag_error("cart_loaded lost after download");
		if (ioctl_wait !== 1'b0) flag_error("ioctl_wait high outside download");
		// RAM model answers the pending write within 8 cycles
		repeat (8) @(negedge clk_1x);
		report_test("cart_write_backpressure", err_before);
	endtask

	task automatic backup_requests;
		int err_before;
		err_before = errors;
		start_download(8'h01);
		@(negedge clk_1x);
		img_size     = 32'h0000_8000;
		img_readonly = 1'b0;
		img_mounted  = 1'b1;
		// Requests are combinational, checked between edges
		#2;
		if (bk_load !== 1'b1) flag_error("bk_load not raised by mounted image");
		@(negedge clk_1x);
		img_mounted = 1'b0;
		osd_status  = 1'b1;
		#2;
		if (bk_load !== 1'b0) flag_error("bk_load held without image or reload");
		if (bk_mounted !== 1'b1) flag_error("bk_mounted clear after writable image");
		if (bk_save !== 1'b1) flag_error("bk_save not raised on menu open");
		@(negedge clk_1x);
		if (bk_save !== 1'b0) flag_error("bk_save held after menu open edge");
		osd_status = 1'b0;
		status[42] = 1'b1;
		repeat (2) @(negedge clk_1x);
		osd_status = 1'b1;
		#2;
		if (bk_save !== 1'b0) flag_error("bk_save raised with autosave off");
		@(negedge clk_1x);
		osd_status = 1'b0;
		status[42] = 1'b0;
		status[40] = 1'b1;
		status[41] = 1'b1;
		@(negedge clk_1x);
		if (bk_load !== 1'b1 || bk_save !== 1'b1) flag_error("menu reload or save bit lost");
		status[40] = 1'b0;
		status[41] = 1'b0;
		// New cart forgets the image, read-only and empty ones are refused
		end_download();
		start_download(8'h01);
		@(negedge clk_1x);
		if (bk_mounted !== 1'b0) flag_error("bk_mounted kept across a new cart download");
		img_readonly = 1'b1;
		img_mounted  = 1'b1;
		@(negedge clk_1x);
		img_mounted = 1'b0;
		@(negedge clk_1x);
		if (bk_mounted !== 1'b0) flag_error("read-only image taken as writable");
		img_readonly = 1'b0;
		img_size     = '0;
		img_mounted  = 1'b1;
		@(negedge clk_1x);
		img_mounted = 1'b0;
		@(negedge clk_1x);
		if (bk_mounted !== 1'b0) flag_error("zero-size image taken as writable");
		end_download();
		report_test("backup_requests", err_before);
	endtask

	task automatic snac_routing;
		int err_before;
		logic [user_w-1:0] exp_out;
		logic [2:0] pin;
		logic sout;
		err_before = errors;
		snac_padindex = 2'd0;
		snac_out      = 1'b1;
		user_in       = '1;
		status[90]    = 1'b1;
		exp_out       = '1;
		repeat (2) @(negedge clk_1x);
		for (int p = 0; p < 4; p++) begin
			pin = pad_pin(2'(p));
			// High then low, so earlier pads must keep their low pin
			for (int v = 0; v < 2; v++) begin
				sout          = (v == 0);
				snac_padindex = 2'(p);
				snac_out      = sout;
				user_in       = {user_w{sout}};
				user_in[pin]  = ~sout;
				exp_out[2]    = 1'b1;
				exp_out[3]    = 1'b1;
				exp_out[6]    = 1'b1;
				exp_out[pin]  = sout;
				@(negedge clk_1x);
				if (user_out !== exp_out)
					flag_error($sformatf("pad %0d user_out %b, expected %b", p, user_out, exp_out));
				if (snac_in !== ~sout) flag_error($sformatf("pad %0d snac_in %b", p, snac_in));
			end
		end
		status[90] = 1'b0;
		snac_out   = 1'b1;
		user_in    = '1;
		repeat (2) @(negedge clk_1x);
		if (user_out !== {user_w{1'b1}}) flag_error("user port not released with SNAC off");
		report_test("snac_routing", err_before);
	endtask

	task automatic option_decode;
		int err_before;
		logic [12:0] exp_arx;
		logic [12:0] exp_ary;
		eeprom_type_e exp_ee;
		err_before = errors;
		for (int a = 0; a < 4; a++) begin
			status[48:47] = 2'(a);
			@(negedge clk_1x);
			exp_arx = (a == 0) ? 13'd4 : 13'(a - 1);
			exp_ary = (a == 0) ? 13'd3 : 13'd0;
			if (video_arx !== exp_arx || video_ary !== exp_ary)
				flag_error($sformatf("aspect %0d gives %0d:%0d", a, video_arx, video_ary));
		end
		status[48:47] = 2'd0;
		for (int s = 0; s < 8; s++) begin
			status[77:75] = 3'(s);
			@(negedge clk_1x);
			case (s)
				1:       exp_ee = eeprom_4k;
				2:       exp_ee = eeprom_16k;
				default: exp_ee = eeprom_none;
			endcase
			if (eeprom_type !== exp_ee)
				flag_error($sformatf("save type %0d gives eeprom_type %0d", s, eeprom_type));
		end
		status[77:75] = 3'd0;
		report_test("option_decode", err_before);
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================
	initial begin
		rst_n          = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		status         = '0;
		osd_status     = 1'b0;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		img_size       = '0;
		snac_padindex  = 2'd0;
		snac_out       = 1'b1;
		user_in        = '1;
		repeat (5) @(negedge clk_1x);
		rst_n = 1'b1;
		check_reset_state();
		pifrom_packing();
		cart_write_backpressure();
		backup_requests();
		snac_routing();
		option_decode();
		$display("Summary: %0d tests run, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule
